// ==== sim.f ====
+incdir+src
+incdir+testbench
src/isa_pkg.sv
src/bus_pkg.sv
src/branch_if.sv
src/fp_compare64.sv
src/branch_eval.sv
src/branch_wb_regs.sv
src/branch_unit_top.sv
testbench/tb_branch_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the branch unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_branch_unit \
	-f sim.f -Mdir obj_dir -o tb_branch_unit
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_branch_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi

// ==== testbench/tb_branch_tasks.svh ====
/*
  Bus tasks, reference model and directed tests of the branch unit testbench.
  Included inside the testbench module and uses its signals directly.
  Float expectations come from real arithmetic on the operand bit patterns.
*/
`ifndef TB_BRANCH_TASKS_SVH
`define TB_BRANCH_TASKS_SVH

// ============================================================================
// Wishbone access
// ============================================================================

// One classic write, held until ack is seen on a falling edge
task automatic wb_write(input logic [`WB_ADDR_W-1:0] adr, input logic [`WB_DATA_W-1:0] data);
	@(negedge clk);
	wb_cyc   = 1'b1;
	wb_stb   = 1'b1;
	wb_we    = 1'b1;
	wb_adr   = adr;
	wb_dat_w = data;
	@(negedge clk);
	while (!wb_ack) @(negedge clk);
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we  = 1'b0;
endtask

// Read data is taken while ack is high
task automatic wb_read(input logic [`WB_ADDR_W-1:0] adr, output logic [`WB_DATA_W-1:0] data);
	@(negedge clk);
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we  = 1'b0;
	wb_adr = adr;
	@(negedge clk);
	while (!wb_ack) @(negedge clk);
	data   = wb_dat_r;
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp) else begin
		$display("CHECK FAILED: %s got %h expected %h", name, got, exp);
		$display("TB FAILED");
		$fatal(1, "Stopping at the first error");
	end
endtask

// ============================================================================
// Reference model
// ============================================================================

// Expected decision, written from the instruction set rules
function automatic logic model_taken(input logic [31:0] instr, input logic [63:0] a,
		input logic [63:0] b);
	logic [6:0] op;
	logic [1:0] cm;
	logic [2:0] cnd;
	logic       is_mcb;
	logic       valid;
	logic       eq;
	logic       lt;
	logic       le;
	logic       unord;
	logic       bitv;
	logic       r;
	real        ra;
	real        rb;
	op     = instr[6:0];
	cm     = instr[8:7];
	is_mcb = (op == OP_MCB);
	valid  = 1'b1;
	case (op)
	OP_BEQ:  cnd = MCB_EQ;
	OP_BNE:  cnd = MCB_NE;
	OP_BLT:  cnd = MCB_LT;
	OP_BLE:  cnd = MCB_LE;
	OP_BGT:  cnd = MCB_GT;
	OP_BGE:  cnd = MCB_GE;
	OP_BBC:  cnd = MCB_BC;
	OP_BBS:  cnd = MCB_BS;
	OP_MCB:  cnd = instr[11:9];
	default: begin
		cnd   = MCB_EQ;
		valid = 1'b0;
	end
	endcase
	ra    = $bitstoreal(a);
	rb    = $bitstoreal(b);
	// An unordered pair satisfies none of the three real relations
	unord = !((ra < rb) || (ra == rb) || (ra > rb));
	bitv  = a[b[`BR_BITIDX_W-1:0]];
	eq    = (a == b);
	lt    = 1'b0;
	case (cm)
	2'd0: lt = $signed(a) < $signed(b);
	2'd1: lt = a < b;
	2'd2: begin
		// Real compares treat the two zeros as equal and are false on NaN
		eq = (ra == rb);
		lt = (ra < rb);
	end
	default: valid = 1'b0;
	endcase
	le = lt | eq;
	case (cnd)
	MCB_EQ:  r = eq;
	MCB_NE:  r = !eq;
	MCB_LT:  r = lt;
	MCB_LE:  r = le;
	MCB_GT:  r = !le;
	MCB_GE:  r = !lt;
	MCB_BC:  r = (cm == 2'd2) ? (is_mcb && unord) : !bitv;
	default: r = (cm == 2'd2) ? (is_mcb && !unord) : bitv;
	endcase
	return valid & r;
endfunction

// ============================================================================
// Stimulus helpers
// ============================================================================

function automatic logic [6:0] plain_opcode(input logic [2:0] i);
	case (i)
	3'd0:    return OP_BEQ;
	3'd1:    return OP_BNE;
	3'd2:    return OP_BLT;
	3'd3:    return OP_BLE;
	3'd4:    return OP_BGT;
	3'd5:    return OP_BGE;
	3'd6:    return OP_BBC;
	default: return OP_BBS;
	endcase
endfunction

// Forms 0 to 7 are plain opcodes and forms 8 to 15 the MCB conditions.
// The displacement bits stay random so the decoder must ignore them
function automatic logic [31:0] build_form(input logic [3:0] k, input logic [1:0] cm,
		input logic [31:0] rnd);
	logic [31:0] instr;
	instr = rnd;
	if (k < 4'd8) begin
		instr[6:0] = plain_opcode(k[2:0]);
	end else begin
		instr[6:0]  = OP_MCB;
		instr[11:9] = k[2:0];
	end
	instr[8:7] = cm;
	return instr;
endfunction

// Loads both operands and the instruction, then reads back the result
task automatic check_branch(input logic [31:0] instr, input logic [63:0] a, input logic [63:0] b);
	logic [31:0] rd;
	logic        exp_t;
	wb_write(REG_A_LO, a[31:0]);
	wb_write(REG_A_HI, a[63:32]);
	wb_write(REG_B_LO, b[31:0]);
	wb_write(REG_B_HI, b[63:32]);
	wb_write(REG_INSTR, instr);
	wb_read(REG_RESULT, rd);
	exp_t = model_taken(instr, a, b);
	check_word("wb_dat_r (REG_RESULT)", rd, {30'd0, 1'b1, exp_t});
	exp_evals++;
	if (exp_t) exp_taken++;
endtask

// ============================================================================
// Directed tests
// ============================================================================

task automatic reset_values();
	logic [31:0] rd;
	wb_read(REG_RESULT, rd);
	check_word("wb_dat_r (REG_RESULT)", rd, 32'h0);
	wb_read(REG_EVALS, rd);
	check_word("wb_dat_r (REG_EVALS)", rd, 32'h0);
	wb_read(REG_TAKEN, rd);
	check_word("wb_dat_r (REG_TAKEN)", rd, 32'h0);
	wb_write(REG_A_LO, 32'h1357_9BDF);
	wb_write(REG_A_HI, 32'h8642_0ECA);
	wb_write(REG_B_LO, 32'hA5A5_5A5A);
	wb_write(REG_B_HI, 32'h0F0F_F0F0);
	wb_read(REG_A_LO, rd);
	check_word("wb_dat_r (REG_A_LO)", rd, 32'h1357_9BDF);
	wb_read(REG_A_HI, rd);
	check_word("wb_dat_r (REG_A_HI)", rd, 32'h8642_0ECA);
	wb_read(REG_B_LO, rd);
	check_word("wb_dat_r (REG_B_LO)", rd, 32'hA5A5_5A5A);
	wb_read(REG_B_HI, rd);
	check_word("wb_dat_r (REG_B_HI)", rd, 32'h0F0F_F0F0);
	// Address 9 is not mapped
	wb_read(4'd9, rd);
	check_word("wb_dat_r (unmapped)", rd, 32'h0);
endtask

// Ack rises on the second edge of a request and stays low while the
// same request is still held afterwards
task automatic ack_handshake();
	@(negedge clk);
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we  = 1'b0;
	wb_adr = REG_A_LO;
	@(negedge clk);
	check_word("wb_ack (first edge)", 32'(wb_ack), 32'h0);
	@(negedge clk);
	check_word("wb_ack (second edge)", 32'(wb_ack), 32'h1);
	check_word("wb_dat_r (REG_A_LO)", wb_dat_r, 32'h1357_9BDF);
	repeat (4) begin
		@(negedge clk);
		check_word("wb_ack (held request)", 32'(wb_ack), 32'h0);
	end
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
endtask

// Edge pairs cover equal values, sign against magnitude and all ones
task automatic integer_compares();
	logic [63:0] ea [3];
	logic [63:0] eb [3];
	logic [63:0] a;
	logic [63:0] b;
	logic [31:0] rnd;
	ea[0] = 64'h0123_4567_89AB_CDEF;
	eb[0] = 64'h0123_4567_89AB_CDEF;
	ea[1] = 64'h8000_0000_0000_0000;
	eb[1] = 64'h0000_0000_0000_0005;
	ea[2] = 64'hFFFF_FFFF_FFFF_FFFF;
	eb[2] = 64'h0000_0000_0000_0001;
	for (int m = 0; m < 2; m++) begin
		for (int p = 0; p < 3; p++) begin
			for (int k = 0; k < 16; k++) begin
				rnd = $random(seed);
				check_branch(build_form(4'(k), 2'(m), rnd), ea[p], eb[p]);
			end
		end
	end
	for (int i = 0; i < 64; i++) begin
		a   = {$random(seed), $random(seed)};
		b   = {$random(seed), $random(seed)};
		// Every eighth pair is equal so the equality forms also hit
		if (i % 8 == 0) b = a;
		rnd = $random(seed);
		check_branch(build_form(rnd[3:0], 2'(i % 2), rnd), a, b);
	end
endtask

task automatic float_compares();
	logic [63:0] fa [7];
	logic [63:0] fb [7];
	logic [31:0] rnd;
	// 1.5 against 2.5, then -2.5 against 1.5
	fa[0] = 64'h3FF8_0000_0000_0000;
	fb[0] = 64'h4004_0000_0000_0000;
	fa[1] = 64'hC004_0000_0000_0000;
	fb[1] = 64'h3FF8_0000_0000_0000;
	// Plus zero against minus zero
	fa[2] = 64'h0000_0000_0000_0000;
	fb[2] = 64'h8000_0000_0000_0000;
	// Minus infinity against plus infinity
	fa[3] = 64'hFFF0_0000_0000_0000;
	fb[3] = 64'h7FF0_0000_0000_0000;
	// Quiet NaN on either side makes the compare unordered
	fa[4] = 64'h7FF8_0000_0000_0000;
	fb[4] = 64'h3FF8_0000_0000_0000;
	fa[5] = 64'h3FF8_0000_0000_0000;
	fb[5] = 64'h7FF8_0000_0000_0000;
	// Minus 2.5 against minus 1.5 orders by the larger magnitude
	fa[6] = 64'hC004_0000_0000_0000;
	fb[6] = 64'hBFF8_0000_0000_0000;
	for (int p = 0; p < 7; p++) begin
		for (int k = 0; k < 16; k++) begin
			rnd = $random(seed);
			check_branch(build_form(4'(k), CM_FLOAT, rnd), fa[p], fb[p]);
		end
	end
endtask

// Upper bits of b are set in half the cases and must not change the index
task automatic bit_tests();
	logic [63:0] ta [2];
	logic [63:0] tb [4];
	logic [63:0] a;
	logic [63:0] b;
	logic [31:0] rnd;
	logic [3:0]  k;
	ta[0] = 64'h8000_0000_0000_0001;
	ta[1] = 64'h7FFF_FFFF_FFFF_FFFE;
	tb[0] = 64'd0;
	tb[1] = 64'd63;
	tb[2] = 64'hFFFF_FFFF_FFFF_FFC0;
	tb[3] = 64'hABCD_0000_1234_00FF;
	for (int m = 0; m < 2; m++) begin
		for (int i = 0; i < 2; i++) begin
			for (int j = 0; j < 4; j++) begin
				rnd = $random(seed);
				check_branch(build_form(4'd6, 2'(m), rnd), ta[i], tb[j]);
				check_branch(build_form(4'd7, 2'(m), rnd), ta[i], tb[j]);
			end
		end
	end
	for (int i = 0; i < 8; i++) begin
		a   = {$random(seed), $random(seed)};
		b   = {$random(seed) | 32'h8000_0000, $random(seed)};
		rnd = $random(seed);
		// Pick BBC, BBS or their MCB forms
		k   = {rnd[1], 2'b11, rnd[0]};
		check_branch(build_form(k, 2'(i % 2), rnd), a, b);
	end
endtask

// Equal operands would take BEQ, so a zero result proves the rejection
task automatic never_taken_cases();
	logic [63:0] v;
	logic [31:0] rnd;
	v   = 64'h0000_0042_0000_0042;
	rnd = $random(seed);
	check_branch(build_form(4'd0, 2'd3, rnd), v, v);
	check_branch(build_form(4'd8, 2'd3, rnd), v, v);
	check_branch({rnd[31:9], 2'd0, 7'h00}, v, v);
	check_branch({rnd[31:9], 2'd1, 7'h13}, v, v);
	check_branch({rnd[31:9], 2'd2, 7'h7F}, v, v);
endtask

task automatic statistics_counters();
	logic [31:0] rd;
	logic [31:0] rnd;
	logic [63:0] a;
	logic [63:0] b;
	// Totals from all earlier tests
	wb_read(REG_EVALS, rd);
	check_word("wb_dat_r (REG_EVALS)", rd, 32'(exp_evals));
	wb_read(REG_TAKEN, rd);
	check_word("wb_dat_r (REG_TAKEN)", rd, 32'(exp_taken));
	wb_write(REG_CLEAR, 32'h0);
	exp_evals = 0;
	exp_taken = 0;
	wb_read(REG_EVALS, rd);
	check_word("wb_dat_r (REG_EVALS)", rd, 32'h0);
	wb_read(REG_TAKEN, rd);
	check_word("wb_dat_r (REG_TAKEN)", rd, 32'h0);
	for (int i = 0; i < 12; i++) begin
		a   = {$random(seed), $random(seed)};
		b   = (i % 3 == 0) ? a : {$random(seed), $random(seed)};
		rnd = $random(seed);
		check_branch(build_form(rnd[3:0], 2'(i % 3), rnd), a, b);
	end
	wb_read(REG_EVALS, rd);
	check_word("wb_dat_r (REG_EVALS)", rd, 32'd12);
	wb_read(REG_TAKEN, rd);
	check_word("wb_dat_r (REG_TAKEN)", rd, 32'(exp_taken));
	wb_write(REG_CLEAR, 32'h0);
	wb_read(REG_EVALS, rd);
	check_word("wb_dat_r (REG_EVALS)", rd, 32'h0);
	wb_read(REG_TAKEN, rd);
	check_word("wb_dat_r (REG_TAKEN)", rd, 32'h0);
endtask

`endif

// ==== testbench/tb_branch_unit.sv ====
/*
  Directed testbench for the branch evaluation unit.
  Inputs change on the falling clock edge and outputs are sampled there too.
  The run stops at the first failed check or at the cycle limit.
*/
`timescale 1ns/1ps
`default_nettype none

`include "branch_consts.svh"

module tb_branch_unit;
	import isa_pkg::*;
	import bus_pkg::*;

	// 100 ns clock period
	localparam int HALF_PERIOD = 50;

	// The full sequence needs roughly 6000 cycles, so this leaves ample margin
	localparam int MAX_CYCLES = 20000;

	logic                  clk;
	logic                  reset;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [`WB_ADDR_W-1:0] wb_adr;
	logic [`WB_DATA_W-1:0] wb_dat_w;
	logic [`WB_DATA_W-1:0] wb_dat_r;
	logic                  wb_ack;

	// Shared random state for all stimulus
	integer seed = 32'h945e5697;

	int cycle_count = 0;

	// Evaluations and taken branches expected since the last counter clear
	int exp_evals;
	int exp_taken;

	branch_unit_top dut_i (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	`include "tb_branch_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// A hung handshake ends the run here
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
			$display("TB FAILED");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	// ==========================================================================
	// Test sequence
	// ==========================================================================
	initial begin
		reset     = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_w  = '0;
		exp_evals = 0;
		exp_taken = 0;
		// Reset stays high for eight rising edges
		repeat (8) @(negedge clk);
		reset = 1'b0;

		reset_values();
		ack_handshake();
		integer_compares();
		float_compares();
		bit_tests();
		never_taken_cases();
		statistics_counters();

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/branch_unit_top.sv ====
/*
  Branch evaluation unit behind a Wishbone classic slave port.
  The host holds cyc and stb until ack and sees one wait state per access.
  Reset is synchronous and active high.
*/
`timescale 1ns/1ps
`default_nettype none

`include "branch_consts.svh"

module branch_unit_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [`WB_ADDR_W-1:0] wb_adr,
	input  logic [`WB_DATA_W-1:0] wb_dat_w,
	output logic [`WB_DATA_W-1:0] wb_dat_r,
	output logic                  wb_ack
);

	// Request and answer between the register block and the evaluator
	branch_if br_if ();

	branch_wb_regs regs_i (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.bus      (br_if.requester)
	);

	// Zero-latency decision on the held request
	branch_eval eval_i (
		.bus (br_if.evaluator)
	);

endmodule

`default_nettype wire

// ==== src/branch_wb_regs.sv ====
/*
  Wishbone classic slave with operand, instruction, result and counter registers.
  Every access succeeds with one wait state, and there are no block transfers.
  A new instruction write overwrites the previous request without queueing.
  The counters wrap silently at their full width.
*/
`timescale 1ns/1ps
`default_nettype none

`include "branch_consts.svh"

module branch_wb_regs (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [`WB_ADDR_W-1:0] wb_adr,
	input  logic [`WB_DATA_W-1:0] wb_dat_w,
	output logic [`WB_DATA_W-1:0] wb_dat_r,
	output logic                  wb_ack,
	branch_if.requester           bus
);
	import isa_pkg::*;
	import bus_pkg::*;

	logic                  pend_q;
	logic                  served_q;
	logic                  acc;
	logic                  clr;
	reg_addr_t             adr;
	logic [`WB_DATA_W-1:0] rd_data;
	value_t                a_q;
	value_t                b_q;
	instruction_t          instr_q;
	logic                  start_q;
	result_t               result_q;
	logic [`BR_CNT_W-1:0]  evals_q;
	logic [`BR_CNT_W-1:0]  taken_q;

	assign adr = reg_addr_t'(wb_adr);

	// =========================================================================
	// Bus handshake
	// =========================================================================

	// A request becomes pending when it is neither pending nor served yet.
	// Served holds until stb drops, so a held request is acknowledged only once
	always_ff @(posedge clk) begin
		if (reset) begin
			pend_q   <= 1'b0;
			served_q <= 1'b0;
		end else begin
			pend_q   <= wb_cyc & wb_stb & ~pend_q & ~served_q;
			served_q <= wb_cyc & wb_stb & (served_q | acc);
		end
	end

	// The access completes on the edge where ack rises
	assign acc = pend_q & wb_cyc & wb_stb;
	assign clr = acc & wb_we & (adr == REG_CLEAR);

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack   <= 1'b0;
			wb_dat_r <= '0;
		end else begin
			wb_ack <= acc;
			// Read data is captured together with ack and holds while it is high
			if (acc && !wb_we) begin
				wb_dat_r <= rd_data;
			end
		end
	end

	// =========================================================================
	// Operand and instruction registers
	// =========================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			a_q     <= '0;
			b_q     <= '0;
			instr_q <= '0;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			if (acc && wb_we) begin
				case (adr)
				REG_A_LO: a_q[`WB_DATA_W-1:0]            <= wb_dat_w;
				REG_A_HI: a_q[`BR_VALUE_W-1:`WB_DATA_W]  <= wb_dat_w;
				REG_B_LO: b_q[`WB_DATA_W-1:0]            <= wb_dat_w;
				REG_B_HI: b_q[`BR_VALUE_W-1:`WB_DATA_W]  <= wb_dat_w;
				REG_INSTR: begin
					// Start is high in the cycle after the instruction loads
					instr_q <= wb_dat_w;
					start_q <= 1'b1;
				end
				default: ;
				endcase
			end
		end
	end

	// The evaluator sees the held request continuously
	assign bus.instr = instr_q;
	assign bus.a     = a_q;
	assign bus.b     = b_q;
	assign bus.start = start_q;

	// =========================================================================
	// Result and statistics
	// =========================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			result_q <= '0;
			evals_q  <= '0;
			taken_q  <= '0;
		end else begin
			if (start_q) begin
				result_q.zero  <= '0;
				result_q.done  <= 1'b1;
				result_q.taken <= bus.takb;
			end
			// A clear wins over a count in the same cycle
			if (clr) begin
				evals_q <= '0;
				taken_q <= '0;
			end else if (start_q) begin
				evals_q <= evals_q + 1'b1;
				if (bus.takb) begin
					taken_q <= taken_q + 1'b1;
				end
			end
		end
	end

	// Unmapped and write-only addresses read as zero
	always_comb begin
		case (adr)
		REG_A_LO:   rd_data = a_q[`WB_DATA_W-1:0];
		REG_A_HI:   rd_data = a_q[`BR_VALUE_W-1:`WB_DATA_W];
		REG_B_LO:   rd_data = b_q[`WB_DATA_W-1:0];
		REG_B_HI:   rd_data = b_q[`BR_VALUE_W-1:`WB_DATA_W];
		REG_RESULT: rd_data = result_q;
		REG_EVALS:  rd_data = evals_q;
		REG_TAKEN:  rd_data = taken_q;
		default:    rd_data = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/branch_eval.sv ====
/*
  Combinational branch decision for one instruction and two operands.
  Plain opcodes and MCB conditions share one condition decoder.
  In float mode the plain bit tests are never taken and the MCB bit tests
  check for unordered and ordered operands instead.
  Reserved compare mode 3 and non-branch opcodes are never taken.
*/
`timescale 1ns/1ps
`default_nettype none

`include "branch_consts.svh"

module branch_eval (
	branch_if.evaluator bus
);
	import isa_pkg::*;

	fcmp_t     fo;
	logic      f_nan;
	logic      i_eq;
	logic      s_lt;
	logic      u_lt;
	logic      bit_val;
	logic      is_float;
	logic      mode_ok;
	logic      c_eq;
	logic      c_lt;
	logic      c_le;
	logic      is_branch;
	logic      is_mcb;
	mcb_cond_t cond;
	logic      hit;

	// Float relations come from the shared double comparator
	fp_compare64 fcmp_i (
		.a    (bus.a),
		.b    (bus.b),
		.o    (fo),
		.nan  (f_nan),
		.inf  (),
		.snan ()
	);

	// Integer relations for both signed and unsigned modes
	assign i_eq = bus.a == bus.b;
	assign s_lt = $signed(bus.a) < $signed(bus.b);
	assign u_lt = bus.a < bus.b;

	// Only the low bits of b select the tested bit of a
	assign bit_val  = bus.a[bus.b[`BR_BITIDX_W-1:0]];
	assign is_float = bus.instr.br.cm == CM_FLOAT;

	// =========================================================================
	// Relation flags for the selected compare mode
	// =========================================================================
	always_comb begin
		mode_ok = 1'b1;
		case (bus.instr.br.cm)
		CM_SIGNED: begin
			c_eq = i_eq;
			c_lt = s_lt;
			c_le = s_lt | i_eq;
		end
		CM_UNSIGNED: begin
			c_eq = i_eq;
			c_lt = u_lt;
			c_le = u_lt | i_eq;
		end
		CM_FLOAT: begin
			c_eq = fo.eq;
			c_lt = fo.lt;
			c_le = fo.le;
		end
		default: begin
			// Mode 3 is reserved
			mode_ok = 1'b0;
			c_eq    = 1'b0;
			c_lt    = 1'b0;
			c_le    = 1'b0;
		end
		endcase
	end

	// Map each plain opcode onto the matching MCB condition
	always_comb begin
		is_branch = 1'b1;
		is_mcb    = 1'b0;
		case (bus.instr.any.opcode)
		OP_BEQ: cond = MCB_EQ;
		OP_BNE: cond = MCB_NE;
		OP_BLT: cond = MCB_LT;
		OP_BLE: cond = MCB_LE;
		OP_BGT: cond = MCB_GT;
		OP_BGE: cond = MCB_GE;
		OP_BBC: cond = MCB_BC;
		OP_BBS: cond = MCB_BS;
		OP_MCB: begin
			cond   = bus.instr.mcb.cnd;
			is_mcb = 1'b1;
		end
		default: begin
			cond      = MCB_EQ;
			is_branch = 1'b0;
		end
		endcase
	end

	// Greater, greater-or-equal and not-equal are the inverted relations,
	// so an unordered float compare takes them
	always_comb begin
		case (cond)
		MCB_EQ:  hit = c_eq;
		MCB_NE:  hit = ~c_eq;
		MCB_LT:  hit = c_lt;
		MCB_LE:  hit = c_le;
		MCB_GT:  hit = ~c_le;
		MCB_GE:  hit = ~c_lt;
		MCB_BC:  hit = is_float ? (is_mcb & f_nan) : ~bit_val;
		MCB_BS:  hit = is_float ? (is_mcb & ~f_nan) : bit_val;
		default: hit = 1'b0;
		endcase
	end

	assign bus.takb = is_branch & mode_ok & hit;

endmodule

`default_nettype wire

// ==== src/fp_compare64.sv ====
/*
  Combinational compare of two IEEE-754 doubles.
  Plus and minus zero compare equal. Any NaN operand clears all compare flags.
  Denormals compare by their raw magnitude, which keeps the ordering correct.
  No rounding modes or exception flags beyond the NaN and infinity indications.
*/
`timescale 1ns/1ps
`default_nettype none

module fp_compare64 (
	input  isa_pkg::value_t a,
	input  isa_pkg::value_t b,
	output isa_pkg::fcmp_t  o,
	output logic            nan,
	output logic            inf,
	output logic            snan
);

	localparam int EXP_W = 11;
	localparam int MAN_W = 52;

	logic             sa;
	logic             sb;
	logic [EXP_W-1:0] ea;
	logic [EXP_W-1:0] eb;
	logic [MAN_W-1:0] ma;
	logic [MAN_W-1:0] mb;
	logic             a_nan;
	logic             b_nan;
	logic             both_zero;
	logic             mag_lt;
	logic             mag_gt;
	logic             eq;
	logic             lt;

	// Split each operand into sign, exponent and fraction
	assign {sa, ea, ma} = a;
	assign {sb, eb, mb} = b;

	// An all-ones exponent marks infinity with a zero fraction and NaN otherwise
	assign a_nan = (&ea) & (|ma);
	assign b_nan = (&eb) & (|mb);
	assign nan   = a_nan | b_nan;
	assign inf   = ((&ea) & ~(|ma)) | ((&eb) & ~(|mb));

	// A clear top fraction bit makes the NaN a signalling one
	assign snan = (a_nan & ~ma[MAN_W-1]) | (b_nan & ~mb[MAN_W-1]);

	// =========================================================================
	// Sign and magnitude ordering
	// =========================================================================

	// Exponent and fraction together order like an unsigned integer
	assign mag_lt    = {ea, ma} < {eb, mb};
	assign mag_gt    = {eb, mb} < {ea, ma};
	assign both_zero = ~|{ea, ma, eb, mb};

	// Zeros of either sign are equal, otherwise the bit patterns must match
	assign eq = both_zero | (a == b);

	always_comb begin
		if (both_zero) begin
			lt = 1'b0;
		end else if (sa != sb) begin
			// Opposite signs, so the negative operand is the smaller one
			lt = sa;
		end else begin
			// Between two negatives the larger magnitude is the smaller value
			lt = sa ? mag_gt : mag_lt;
		end
	end

	// An unordered compare reports no relation at all
	assign o.eq = eq & ~nan;
	assign o.lt = lt & ~nan;
	assign o.le = (lt | eq) & ~nan;

endmodule

`default_nettype wire

// ==== src/branch_if.sv ====
/*
  Evaluation request between the register block and the evaluator.
  takb is combinational from instr, a and b and has no latency.
  start is a single-cycle pulse, and the requester samples takb while it is high.
*/
`timescale 1ns/1ps
`default_nettype none

interface branch_if;
	import isa_pkg::*;

	// Instruction and operands of the current request
	instruction_t instr;
	value_t       a;
	value_t       b;

	// High for the one cycle in which the answer is taken over
	logic start;

	// Branch decision for the current request
	logic takb;

	// The register block owns the request and consumes the answer
	modport requester (
		output instr,
		output a,
		output b,
		output start,
		input  takb
	);

	// The evaluator only looks at the request contents
	modport evaluator (
		input  instr,
		input  a,
		input  b,
		output takb
	);

endinterface

`default_nettype wire

// ==== src/bus_pkg.sv ====
/*
  Register map and status word of the Wishbone register block.
  Addresses are word addresses and every register is one bus word.
  Unlisted addresses read as zero and ignore writes.
*/
`default_nettype none

`include "branch_consts.svh"

package bus_pkg;

	typedef enum logic [`WB_ADDR_W-1:0] {
		// Operand halves, readable and writable
		REG_A_LO   = 'd0,
		REG_A_HI   = 'd1,
		REG_B_LO   = 'd2,
		REG_B_HI   = 'd3,
		// Writing the instruction starts one evaluation
		REG_INSTR  = 'd4,
		REG_RESULT = 'd5,
		// Statistics counters, read only
		REG_EVALS  = 'd6,
		REG_TAKEN  = 'd7,
		// Any write here zeroes both counters
		REG_CLEAR  = 'd8
	} reg_addr_t;

	// Done stays set once the first evaluation has finished
	typedef struct packed {
		logic [`WB_DATA_W-3:0] zero;
		logic                  done;
		logic                  taken;
	} result_t;

endpackage

`default_nettype wire

// ==== src/isa_pkg.sv ====
/*
  Instruction set types seen by the branch evaluator.
  Only branch opcodes are listed and any other opcode counts as a non-branch.
  Compare mode 3 is reserved and never leads to a taken branch.
*/
`default_nettype none

`include "branch_consts.svh"

package isa_pkg;

	// =========================================================================
	// Opcodes and condition codes
	// =========================================================================

	// Plain branch opcodes plus the multi-condition form
	typedef enum logic [6:0] {
		OP_BEQ = 7'h20,
		OP_BNE = 7'h21,
		OP_BLT = 7'h22,
		OP_BLE = 7'h23,
		OP_BGT = 7'h24,
		OP_BGE = 7'h25,
		OP_BBC = 7'h26,
		OP_BBS = 7'h27,
		OP_MCB = 7'h28
	} opcode_t;

	// The MCB condition field carries the same eight tests in the plain order
	typedef enum logic [2:0] {
		MCB_EQ = 3'd0,
		MCB_NE = 3'd1,
		MCB_LT = 3'd2,
		MCB_LE = 3'd3,
		MCB_GT = 3'd4,
		MCB_GE = 3'd5,
		MCB_BC = 3'd6,
		MCB_BS = 3'd7
	} mcb_cond_t;

	typedef enum logic [1:0] {
		CM_SIGNED   = 2'd0,
		CM_UNSIGNED = 2'd1,
		CM_FLOAT    = 2'd2
	} cmp_mode_t;

	// =========================================================================
	// Instruction word
	// =========================================================================

	// Each view keeps the opcode in bits 6..0
	typedef union packed {
		struct packed {
			logic [`BR_INSTR_W-8:0] rest;
			opcode_t                opcode;
		} any;
		struct packed {
			logic [`BR_INSTR_W-10:0] disp;
			cmp_mode_t               cm;
			opcode_t                 opcode;
		} br;
		struct packed {
			logic [`BR_INSTR_W-13:0] disp;
			mcb_cond_t               cnd;
			cmp_mode_t               cm;
			opcode_t                 opcode;
		} mcb;
	} instruction_t;

	typedef logic [`BR_VALUE_W-1:0] value_t;

	// Float compare flags, all clear when the compare is unordered
	typedef struct packed {
		logic le;
		logic lt;
		logic eq;
	} fcmp_t;

endpackage

`default_nettype wire

// ==== src/branch_consts.svh ====
/*
  Width and address constants for the branch evaluation unit.
  An operand must be exactly two bus words wide, because the register block
  assembles each operand from a low and a high half.
  The bit index width must cover every bit position of an operand.
*/
`ifndef BRANCH_CONSTS_SVH
`define BRANCH_CONSTS_SVH

// Operand width of the processor
`define BR_VALUE_W 64

// Low bits of operand b that select a bit of operand a in bit tests
`define BR_BITIDX_W 6

// Width of one instruction word
`define BR_INSTR_W 32

// Wishbone data bus width
`define WB_DATA_W 32

// Word address width, which covers nine registers
`define WB_ADDR_W 4

// Width of the evaluation and taken-branch counters
`define BR_CNT_W 32

`endif
